//--- build.f
common/parking_pkg.sv
hdl/order_queue.sv
hdl/spot_allocator.sv
hdl/fee_meter.sv
hdl/spot_registry.sv
elevator/elevator_controller.sv
hdl/parking_tower_top.sv
tests/parking_tower_sva.sv
tests/parking_tower_tb.sv

//--- common/parking_pkg.sv
`default_nettype none

package parking_pkg;

    typedef logic [15:0] plate_t;   // 0 marks an empty spot
    typedef logic [2:0]  floor_t;
    typedef logic [3:0]  spot_t;    // {floor, side}
    typedef logic [7:0]  fee_t;
    typedef logic [3:0]  count_t;
    typedef logic [1:0]  rate_t;

    localparam int FLOOR_COUNT = 7;
    localparam int SPOT_COUNT  = 2 * FLOOR_COUNT;

    localparam logic [3:0] HANDICAP_TAG = 4'd9;
    localparam logic [3:0] HYBRID_TAG   = 4'd8;

    localparam fee_t FEE_MAX = 8'd255;

    // Odd floors hold SUVs, bit i is spot index i
    localparam logic [SPOT_COUNT-1:0] SUV_SPOT_MASK      = 14'b11_0011_0011_0011;
    // Side 0 of floors 1 and 2
    localparam logic [SPOT_COUNT-1:0] HANDICAP_SPOT_MASK = 14'b00_0000_0000_0101;

    localparam count_t SUV_SPOT_COUNT   = 4'd8;
    localparam count_t SEDAN_SPOT_COUNT = 4'd6;

    // Index 0 is floor 1 side 0, so the address is simply offset by two
    function automatic spot_t spot_of(input int idx);
        return spot_t'(idx + 2);
    endfunction

    function automatic int index_of(input spot_t spot);
        return int'(spot) - 2;
    endfunction

    function automatic rate_t plate_rate(input plate_t plate);
        if (plate[15:12] == HANDICAP_TAG)
            return 2'd0;
        else if (plate[15:12] == HYBRID_TAG)
            return 2'd1;
        else
            return 2'd2;
    endfunction

    function automatic fee_t fee_add(input fee_t fee, input rate_t rate);
        logic [8:0] sum;
        sum = {1'b0, fee} + {7'd0, rate};
        return (sum > {1'b0, FEE_MAX}) ? FEE_MAX : sum[7:0];  // Saturate
    endfunction

endpackage

`default_nettype wire

//--- elevator/elevator_controller.sv
`timescale 1ns/10ps
`default_nettype none

module elevator_controller
    import parking_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   queue_empty,
    input  plate_t head_plate,
    input  logic   head_is_out,
    input  spot_t  target_spot,
    input  logic   target_valid,
    output logic   pop,
    output logic   park,
    output logic   remove,
    output spot_t  park_spot,
    output plate_t park_plate,
    output spot_t  remove_spot,
    output logic   rejected,
    output logic   car_out_ready,
    output floor_t current_floor
);

    typedef enum logic [1:0] {
        IDLE,
        CLIMB,
        DESCEND
    } state_t;

    state_t state;
    plate_t plate_q;    // Order taken at pop
    logic   is_out_q;
    spot_t  target_q;
    logic   at_target;

    // Order and target are taken in the same cycle
    assign pop      = (state == IDLE) && (current_floor == '0) && !queue_empty;
    assign rejected = pop && !target_valid;   // Order is simply discarded

    assign at_target = (state == CLIMB) && (current_floor == target_q[3:1]);
    assign park      = at_target && !is_out_q;
    assign remove    = at_target && is_out_q;

    assign car_out_ready = (state == DESCEND) && (current_floor == '0) && is_out_q;

    assign park_spot   = target_q;
    assign remove_spot = target_q;
    assign park_plate  = plate_q;

    always_ff @(posedge clock) begin
        if (pop) begin
            plate_q  <= head_plate;
            is_out_q <= head_is_out;
            target_q <= target_spot;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= IDLE;
            current_floor <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pop && target_valid) begin
                        state         <= CLIMB;
                        current_floor <= current_floor + 1'b1;  // Every spot is at floor 1 or up
                    end
                end
                CLIMB: begin
                    if (at_target) begin
                        state         <= DESCEND;
                        current_floor <= current_floor - 1'b1;
                    end else begin
                        current_floor <= current_floor + 1'b1;
                    end
                end
                DESCEND: begin
                    if (current_floor == '0)
                        state <= IDLE;
                    else
                        current_floor <= current_floor - 1'b1;
                end
                default: begin
                    state         <= IDLE;
                    current_floor <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/fee_meter.sv
`timescale 1ns/10ps
`default_nettype none

module fee_meter
    import parking_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   park,
    input  plate_t plate,
    output fee_t   fee
);

    rate_t rate;  // Charge per cycle of the car now in the spot

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rate <= '0;
            fee  <= '0;
        end else if (park) begin
            rate <= plate_rate(plate);
            fee  <= '0;                  // New car starts from zero
        end else begin
            fee <= fee_add(fee, rate);
        end
    end

endmodule

`default_nettype wire

//--- hdl/order_queue.sv
`timescale 1ns/10ps
`default_nettype none

module order_queue
    import parking_pkg::*;
#(
    parameter int queue_depth = 7
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   in_mode,
    input  logic   out_mode,
    input  plate_t order_plate,
    input  logic   pop,
    output plate_t head_plate,
    output logic   head_is_out,
    output logic   queue_empty,
    output logic   queue_full
);

    localparam int ptr_width   = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int count_width = $clog2(queue_depth + 1);

    plate_t               plate_mem [queue_depth];
    logic                 kind_mem  [queue_depth];  // High for a fetch order
    logic [ptr_width-1:0] rd_ptr;
    logic [ptr_width-1:0] wr_ptr;
    logic [count_width-1:0] count;
    logic                 push;
    logic                 do_pop;

    // Both strobes at once is ambiguous, so the order is dropped
    assign push   = (in_mode ^ out_mode) && !queue_full;
    assign do_pop = pop && !queue_empty;

    assign queue_empty = (count == '0);
    assign queue_full  = (count == count_width'(queue_depth));
    assign head_plate  = plate_mem[rd_ptr];
    assign head_is_out = kind_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            plate_mem[wr_ptr] <= order_plate;
            kind_mem[wr_ptr]  <= out_mode;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == ptr_width'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_width'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/parking_tower_top.sv
`timescale 1ns/10ps
`default_nettype none

module parking_tower_top
    import parking_pkg::*;
#(
    parameter int queue_depth = 7
) (
    input  logic   clock,
    input  logic   reset,
    input  plate_t order_plate,
    input  logic   in_mode,
    input  logic   out_mode,
    output logic   queue_full,
    output floor_t current_floor,
    output logic   park,
    output spot_t  park_spot,
    output logic   remove,
    output spot_t  remove_spot,
    output logic   rejected,
    output logic   car_out_ready,
    output plate_t out_plate,
    output fee_t   fee,
    output count_t empty_suv,
    output count_t empty_sedan,
    output logic   full_suv,
    output logic   full_sedan
);

    plate_t head_plate;
    logic   head_is_out;
    logic   queue_empty;
    logic   pop;
    spot_t  target_spot;
    logic   target_valid;
    plate_t park_plate;
    plate_t spot_plates [SPOT_COUNT];

    order_queue #(
        .queue_depth (queue_depth)
    ) queue_inst (
        .clock       (clock),
        .reset       (reset),
        .in_mode     (in_mode),
        .out_mode    (out_mode),
        .order_plate (order_plate),
        .pop         (pop),
        .head_plate  (head_plate),
        .head_is_out (head_is_out),
        .queue_empty (queue_empty),
        .queue_full  (queue_full)
    );

    spot_allocator allocator_inst (
        .head_plate   (head_plate),
        .head_is_out  (head_is_out),
        .spot_plates  (spot_plates),
        .full_sedan   (full_sedan),
        .target_spot  (target_spot),
        .target_valid (target_valid)
    );

    elevator_controller elevator_inst (
        .clock         (clock),
        .reset         (reset),
        .queue_empty   (queue_empty),
        .head_plate    (head_plate),
        .head_is_out   (head_is_out),
        .target_spot   (target_spot),
        .target_valid  (target_valid),
        .pop           (pop),
        .park          (park),
        .remove        (remove),
        .park_spot     (park_spot),
        .park_plate    (park_plate),
        .remove_spot   (remove_spot),
        .rejected      (rejected),
        .car_out_ready (car_out_ready),
        .current_floor (current_floor)
    );

    spot_registry registry_inst (
        .clock       (clock),
        .reset       (reset),
        .park        (park),
        .remove      (remove),
        .park_spot   (park_spot),
        .park_plate  (park_plate),
        .remove_spot (remove_spot),
        .spot_plates (spot_plates),
        .out_plate   (out_plate),
        .out_fee     (fee),       // Fee of the last departed car
        .empty_suv   (empty_suv),
        .empty_sedan (empty_sedan),
        .full_suv    (full_suv),
        .full_sedan  (full_sedan)
    );

endmodule

`default_nettype wire

//--- hdl/spot_allocator.sv
`timescale 1ns/10ps
`default_nettype none

module spot_allocator
    import parking_pkg::*;
(
    input  plate_t head_plate,
    input  logic   head_is_out,
    input  plate_t spot_plates [SPOT_COUNT],
    input  logic   full_sedan,
    output spot_t  target_spot,
    output logic   target_valid
);

    logic                  is_suv;
    logic                  handicap;
    logic [SPOT_COUNT-1:0] class_spots;
    logic [SPOT_COUNT-1:0] empty_spots;
    logic [SPOT_COUNT-1:0] holds_plate;
    logic [SPOT_COUNT-1:0] eligible;
    logic [SPOT_COUNT-1:0] hit;

    assign is_suv   = head_plate[0];
    assign handicap = (head_plate[15:12] == HANDICAP_TAG);

    // Sedans overflow onto SUV floors once the even floors are full
    always_comb begin
        if (is_suv)
            class_spots = SUV_SPOT_MASK;
        else if (full_sedan)
            class_spots = '1;
        else
            class_spots = ~SUV_SPOT_MASK;
    end

    always_comb begin
        for (int i = 0; i < SPOT_COUNT; i++) begin
            empty_spots[i] = (spot_plates[i] == '0);
            holds_plate[i] = (spot_plates[i] == head_plate);  // Parallel plate match
        end
    end

    assign eligible = class_spots & empty_spots & (handicap ? '1 : ~HANDICAP_SPOT_MASK);

    // Plate 0 never parks and never matches
    assign hit = (head_plate == '0) ? '0 : (head_is_out ? holds_plate : eligible);

    // Lowest index wins, which is lowest floor then side 0
    always_comb begin
        target_valid = 1'b0;
        target_spot  = '0;
        for (int i = SPOT_COUNT - 1; i >= 0; i--) begin
            if (hit[i]) begin
                target_valid = 1'b1;
                target_spot  = spot_of(i);
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/spot_registry.sv
`timescale 1ns/10ps
`default_nettype none

module spot_registry
    import parking_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   park,
    input  logic   remove,
    input  spot_t  park_spot,
    input  plate_t park_plate,
    input  spot_t  remove_spot,
    output plate_t spot_plates [SPOT_COUNT],
    output plate_t out_plate,
    output fee_t   out_fee,
    output count_t empty_suv,
    output count_t empty_sedan,
    output logic   full_suv,
    output logic   full_sedan
);

    fee_t                  spot_fees [SPOT_COUNT];
    logic [SPOT_COUNT-1:0] meter_park;
    count_t                free_suv;
    count_t                free_sedan;

    generate
        for (genvar i = 0; i < SPOT_COUNT; i++) begin : g_meter
            assign meter_park[i] = park && (park_spot == spot_of(i));

            fee_meter meter_inst (
                .clock (clock),
                .reset (reset),
                .park  (meter_park[i]),
                .plate (park_plate),
                .fee   (spot_fees[i])
            );
        end
    endgenerate

    // Plate table, park and remove never arrive together
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < SPOT_COUNT; i++)
                spot_plates[i] <= '0;
        end else if (park) begin
            spot_plates[index_of(park_spot)] <= park_plate;
        end else if (remove) begin
            spot_plates[index_of(remove_spot)] <= '0;
        end
    end

    // The removal cycle itself is charged too
    always_ff @(posedge clock) begin
        if (remove) begin
            out_plate <= spot_plates[index_of(remove_spot)];
            out_fee   <= fee_add(spot_fees[index_of(remove_spot)],
                                 plate_rate(spot_plates[index_of(remove_spot)]));
        end
    end

    always_comb begin
        free_suv   = '0;
        free_sedan = '0;
        for (int i = 0; i < SPOT_COUNT; i++) begin
            if (spot_plates[i] == '0) begin
                if (SUV_SPOT_MASK[i])
                    free_suv = free_suv + 1'b1;
                else
                    free_sedan = free_sedan + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            empty_suv   <= SUV_SPOT_COUNT;     // Tower starts empty
            empty_sedan <= SEDAN_SPOT_COUNT;
            full_suv    <= 1'b0;
            full_sedan  <= 1'b0;
        end else begin
            empty_suv   <= free_suv;
            empty_sedan <= free_sedan;
            full_suv    <= (free_suv == '0);
            full_sedan  <= (free_sedan == '0);
        end
    end

endmodule

`default_nettype wire

//--- tests/parking_tower_stimulus.txt
# kind (0 park, 1 fetch)  plate (hex)  spot (hex, 0 = rejected)  dropped  burst
# burst 1 sends the next order on the next clock, 0 waits until the tower is idle
0 1001 3 0 0
0 2002 5 0 0
0 9003 2 0 0
0 9004 4 0 0
0 8005 6 0 0
0 1006 8 0 0
1 1001 3 0 0
1 9003 2 0 0
1 8005 6 0 0
1 7777 0 0 0
0 0000 0 0 0
0 200a 9 0 0
0 200c c 0 0
0 200e d 0 0
0 2010 3 0 0
1 2002 5 0 0
0 2012 5 0 0
0 3001 6 0 0
0 3003 7 0 0
0 3005 a 0 0
0 3007 b 0 0
0 3009 e 0 1
0 300b f 0 1
0 300d 0 0 1
0 9011 2 0 1
0 2020 0 0 1
1 3001 6 0 1
0 2022 6 0 1
1 1006 8 0 1
0 4444 0 1 0
1 2022 6 0 0
1 9011 2 0 0

//--- tests/parking_tower_sva.sv
`timescale 1ns/10ps
`default_nettype none

module parking_tower_sva
    import parking_pkg::*;
(
    input logic   clock,
    input logic   reset,
    input floor_t current_floor,
    input logic   pop,
    input logic   park,
    input logic   remove,
    input logic   rejected,
    input logic   car_out_ready
);

    int unsigned failures = 0;  // Count of failed assertions

    // One floor per clock at most
    floor_step: assert property (@(posedge clock) disable iff (reset)
        (current_floor == $past(current_floor)) ||
        (int'(current_floor) == int'($past(current_floor)) + 1) ||
        (int'(current_floor) + 1 == int'($past(current_floor))))
    else begin
        failures++;
        $error("Elevator moved more than one floor in a cycle");
    end

    // Exclusive single-cycle pulses
    park_remove_exclusive: assert property (@(posedge clock) disable iff (reset)
        (park || remove) |-> !(park && remove) && !$past(park || remove))
    else begin
        failures++;
        $error("Park and remove pulsed together or for more than one cycle");
    end

    // The car is handed out as the cab arrives from floor 1
    out_at_ground: assert property (@(posedge clock) disable iff (reset)
        car_out_ready |-> (current_floor == '0) && ($past(current_floor) == 3'd1))
    else begin
        failures++;
        $error("Car handed out away from floor 0");
    end

    // A new order is only taken by an idle cab at the ground floor
    pop_when_idle: assert property (@(posedge clock) disable iff (reset)
        pop |-> ($past(current_floor) == '0) && (!$past(pop) || $past(rejected)))
    else begin
        failures++;
        $error("Order popped while the elevator was busy");
    end

endmodule

`default_nettype wire

//--- tests/parking_tower_tb.sv
`timescale 1ns/10ps
`default_nettype none

module parking_tower_tb
    import parking_pkg::*;
();

    localparam int queue_depth = 7;

    logic   clock;
    logic   reset;
    plate_t order_plate;
    logic   in_mode;
    logic   out_mode;
    logic   queue_full;
    floor_t current_floor;
    logic   park;
    spot_t  park_spot;
    logic   remove;
    spot_t  remove_spot;
    logic   rejected;
    logic   car_out_ready;
    plate_t out_plate;
    fee_t   fee;
    count_t empty_suv;
    count_t empty_sedan;
    logic   full_suv;
    logic   full_sedan;

    // Stimulus table as read from the file
    int     st_kind [$];
    plate_t st_plate [$];
    spot_t  st_spot [$];
    int     st_drop [$];
    int     st_burst [$];

    // Orders accepted by the queue and not yet finished, oldest first
    int     exp_kind [$];
    plate_t exp_plate [$];
    spot_t  exp_spot [$];

    plate_t owner [SPOT_COUNT];
    int     park_cycle [SPOT_COUNT];
    int     cycle = 0;
    int     count_delay = 0;
    bit     loaded = 0;
    fee_t   fee_expected;

    parking_tower_top #(
        .queue_depth (queue_depth)
    ) parking_tower_inst (
        .clock         (clock),
        .reset         (reset),
        .order_plate   (order_plate),
        .in_mode       (in_mode),
        .out_mode      (out_mode),
        .queue_full    (queue_full),
        .current_floor (current_floor),
        .park          (park),
        .park_spot     (park_spot),
        .remove        (remove),
        .remove_spot   (remove_spot),
        .rejected      (rejected),
        .car_out_ready (car_out_ready),
        .out_plate     (out_plate),
        .fee           (fee),
        .empty_suv     (empty_suv),
        .empty_sedan   (empty_sedan),
        .full_suv      (full_suv),
        .full_sedan    (full_sedan)
    );

    bind elevator_controller parking_tower_sva sva_inst (
        .clock         (clock),
        .reset         (reset),
        .current_floor (current_floor),
        .pop           (pop),
        .park          (park),
        .remove        (remove),
        .rejected      (rejected),
        .car_out_ready (car_out_ready)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    always @(posedge clock) cycle <= cycle + 1;

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_spot(input string name, input spot_t expected, input spot_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_floor(input string name, input floor_t expected, input floor_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_plate(input string name, input plate_t expected, input plate_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_fee(input string name, input fee_t expected, input fee_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input bit expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %b, actual %b", name, expected, actual);
            stop_run();
        end
    endtask

    // Handicapped free, hybrid 1, the rest 2
    function automatic fee_t expected_fee(input plate_t plate, input int cycles);
        int rate;
        int total;
        if (plate[15:12] == 4'h9)
            rate = 0;
        else if (plate[15:12] == 4'h8)
            rate = 1;
        else
            rate = 2;
        total = rate * cycles;
        return (total > 255) ? fee_t'(255) : fee_t'(total);
    endfunction

    function automatic int index_from_spot(input spot_t spot);
        return 2 * (int'(spot[3:1]) - 1) + int'(spot[0]);
    endfunction

    task automatic check_counts();
        int occ_suv;
        int occ_sedan;
        occ_suv   = 0;
        occ_sedan = 0;
        for (int i = 0; i < SPOT_COUNT; i++) begin
            if (owner[i] != '0) begin
                if ((i / 2) % 2 == 0)  // Floors 1, 3, 5, 7
                    occ_suv++;
                else
                    occ_sedan++;
            end
        end
        check_count("empty_suv", count_t'(8 - occ_suv), empty_suv);
        check_count("empty_sedan", count_t'(6 - occ_sedan), empty_sedan);
        check_flag("full_suv", occ_suv == 8, full_suv);
        check_flag("full_sedan", occ_sedan == 6, full_sedan);
    endtask

    task automatic read_stimulus();
        int     fd;
        int     fields;
        int     kind;
        int     drop;
        int     burst;
        plate_t plate;
        spot_t  spot;
        string  line;
        fd = $fopen("tests/parking_tower_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            stop_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%d %h %h %d %d", kind, plate, spot, drop, burst);
                if (fields == 5) begin
                    st_kind.push_back(kind);
                    st_plate.push_back(plate);
                    st_spot.push_back(spot);
                    st_drop.push_back(drop);
                    st_burst.push_back(burst);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_order(input int i);
        @(posedge clock);
        in_mode     <= (st_kind[i] == 0);
        out_mode    <= (st_kind[i] == 1);
        order_plate <= st_plate[i];
        if (st_drop[i] != 0) begin
            @(negedge clock);
            check_flag($sformatf("queue_full at order %h", st_plate[i]), 1'b1, queue_full);
        end else begin
            exp_kind.push_back(st_kind[i]);
            exp_plate.push_back(st_plate[i]);
            exp_spot.push_back(st_spot[i]);
        end
    endtask

    task automatic wait_idle();
        @(posedge clock);
        in_mode  <= 1'b0;
        out_mode <= 1'b0;
        while (exp_kind.size() != 0 || current_floor != '0)
            @(negedge clock);
        repeat (2) @(negedge clock);
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        int found;
        int idx;
        if (!reset) begin
            if (parking_tower_inst.elevator_inst.sva_inst.failures != 0) begin
                $display("An assertion on the elevator failed");
                stop_run();
            end
            if (count_delay > 0) begin
                count_delay--;
                if (count_delay == 0)
                    check_counts();
            end
            if ((park || remove || rejected || car_out_ready) && exp_kind.size() == 0) begin
                $display("An order event occurred with no order pending");
                stop_run();
            end
            if (park) begin
                check_flag("order kind at park", 1'b0, exp_kind[0] != 0);
                check_spot($sformatf("park of %h", exp_plate[0]), exp_spot[0], park_spot);
                check_floor($sformatf("floor at park of %h", exp_plate[0]), exp_spot[0][3:1],
                            current_floor);
                idx = index_from_spot(park_spot);
                owner[idx]      = exp_plate[0];
                park_cycle[idx] = cycle;
                void'(exp_kind.pop_front());
                void'(exp_plate.pop_front());
                void'(exp_spot.pop_front());
                count_delay = 2;
            end
            if (remove) begin
                check_flag("order kind at remove", 1'b1, exp_kind[0] != 0);
                check_spot($sformatf("remove of %h", exp_plate[0]), exp_spot[0], remove_spot);
                check_floor($sformatf("floor at remove of %h", exp_plate[0]), exp_spot[0][3:1],
                            current_floor);
                found = -1;
                for (int i = 0; i < SPOT_COUNT; i++)
                    if (owner[i] == exp_plate[0])
                        found = i;
                if (found < 0) begin
                    $display("Plate %h was fetched but never seen parking", exp_plate[0]);
                    stop_run();
                end
                check_spot("remove vs recorded park", spot_t'(2 * (found / 2 + 1) + found % 2),
                           remove_spot);
                fee_expected = expected_fee(exp_plate[0], cycle - park_cycle[found]);
                owner[found] = '0;
                count_delay  = 2;
            end
            if (car_out_ready) begin
                check_plate("out_plate", exp_plate[0], out_plate);
                check_fee($sformatf("fee of %h", exp_plate[0]), fee_expected, fee);
                void'(exp_kind.pop_front());
                void'(exp_plate.pop_front());
                void'(exp_spot.pop_front());
            end
            if (rejected) begin
                check_spot($sformatf("rejection of %h", exp_plate[0]), exp_spot[0], 4'h0);
                void'(exp_kind.pop_front());
                void'(exp_plate.pop_front());
                void'(exp_spot.pop_front());
            end
        end
    end

    // Watchdog sized from the number of orders
    initial begin
        realtime limit;
        wait (loaded);
        limit = real'(st_kind.size() * (2 * FLOOR_COUNT + 6) * 20) + 1000.0;
        #(limit);
        $display("Timeout: the run hung before all orders completed");
        stop_run();
    end

    initial begin
        reset       = 1'b1;
        in_mode     = 1'b0;
        out_mode    = 1'b0;
        order_plate = '0;
        for (int i = 0; i < SPOT_COUNT; i++) begin
            owner[i]      = '0;
            park_cycle[i] = 0;
        end
        read_stimulus();
        loaded = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(negedge clock);
        check_counts();
        for (int i = 0; i < st_kind.size(); i++) begin
            drive_order(i);
            if (st_burst[i] == 0)
                wait_idle();
        end
        if (parking_tower_inst.elevator_inst.sva_inst.failures == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Assertion failures were reported during the run");
            stop_run();
        end
    end

endmodule

`default_nettype wire
